//--- all.f
+incdir+hdl
hdl/mem_bus_pkg.sv
hdl/cache_line_pkg.sv
hdl/param_mem.sv
hdl/cache_store.sv
hdl/cache_ctrl.sv
hdl/main_ram.sv
hdl/cache_top.sv
dv/cache_props.sv
dv/cache_tb.sv

//--- dv/cache_props.sv
// assertions on the controller's ram strobes and cpu acknowledge
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_props
(
    input  logic clk,
    input  logic rst_i,
    input  logic rd_strb_i,                     // ram read strobe
    input  logic we_strb_i,                     // ram write strobe
    input  logic done_i,                        // ram read done
    input  logic ack_i                          // cpu acknowledge
);

    // done comes exactly RAM_LAT cycles after a read strobe
    a_done_after_rd: assert property (@(posedge clk) disable iff (rst_i)
        $past(rd_strb_i, `RAM_LAT) |-> done_i)
        else $error("ram done missing RAM_LAT cycles after the read strobe");

    // and never without one
    a_done_has_rd: assert property (@(posedge clk) disable iff (rst_i)
        done_i |-> $past(rd_strb_i, `RAM_LAT))
        else $error("ram done without a read strobe RAM_LAT cycles before");

    a_ack_pulse: assert property (@(posedge clk) disable iff (rst_i)
        ack_i |=> !ack_i)
        else $error("cpu acknowledge longer than one cycle");

    a_rd_we_excl: assert property (@(posedge clk) disable iff (rst_i)
        !(rd_strb_i && we_strb_i))
        else $error("ram read and write strobes high together");

endmodule

bind cache_ctrl cache_props props0
(
    .clk       ( clk        ),
    .rst_i     ( rst_i      ),
    .rd_strb_i ( ram_rd_o   ),
    .we_strb_i ( ram_we_o   ),
    .done_i    ( ram_done_i ),
    .ack_i     ( cpu_ack_o  )
);

//--- dv/cache_tb.sv
// testbench of the write-through cache
// directed table, shadow model, random requests, watchdog
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tb;

    localparam int n_tab    = 17;
    localparam int n_rand   = 40;
    localparam int ack_wait = `RAM_LAT + 4;         // longest request plus margin
    localparam int slot_ns  = (`RAM_LAT + 4) * 100; // time budget per request

    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [31:0] rdata;                         // expected load data
        logic        hit;                           // expected hit flag
    } entry_t;

    // store rows check the hit flag only
    localparam entry_t tab [n_tab] = '{
        '{1'b0, 32'h0000_0040, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0},  // cold miss
        '{1'b0, 32'h0000_0040, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b1},  // same line hits
        '{1'b1, 32'h0000_0080, 32'hdead_beef, 4'hf, 32'h0000_0000, 1'b0},  // nothing valid yet
        '{1'b0, 32'h0000_0080, 32'h0000_0000, 4'h0, 32'hdead_beef, 1'b1},
        '{1'b1, 32'h0000_0080, 32'hcafe_0000, 4'hc, 32'h0000_0000, 1'b1},  // upper half
        '{1'b0, 32'h0000_0080, 32'h0000_0000, 4'h0, 32'hcafe_beef, 1'b1},
        '{1'b1, 32'h0000_0340, 32'ha5a5_a5a5, 4'hf, 32'h0000_0000, 1'b0},  // takes line 0x10
        '{1'b0, 32'h0000_0040, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0},  // takes it back
        '{1'b1, 32'h0000_0340, 32'h1122_3344, 4'h3, 32'h0000_0000, 1'b0},  // two bytes valid
        '{1'b0, 32'h0000_0340, 32'h0000_0000, 4'h0, 32'ha5a5_3344, 1'b0},  // merged in ram
        '{1'b0, 32'h0000_0340, 32'h0000_0000, 4'h0, 32'ha5a5_3344, 1'b1},
        '{1'b1, 32'h0000_0500, 32'h5555_0500, 4'hf, 32'h0000_0000, 1'b0},  // index 0, tag 5
        '{1'b1, 32'h0000_0900, 32'h9999_0900, 4'hf, 32'h0000_0000, 1'b0},  // index 0, tag 9
        '{1'b0, 32'h0000_0500, 32'h0000_0000, 4'h0, 32'h5555_0500, 1'b0},
        '{1'b0, 32'h0000_0900, 32'h0000_0000, 4'h0, 32'h9999_0900, 1'b0},
        '{1'b0, 32'h0000_0500, 32'h0000_0000, 4'h0, 32'h5555_0500, 1'b0},
        '{1'b0, 32'h0000_0900, 32'h0000_0000, 4'h0, 32'h9999_0900, 1'b0}
    };

    logic               clk;
    logic               rst_i;
    logic               cpu_req_i;
    logic               cpu_we_i;
    mem_bus_pkg::addr_t cpu_addr_i;
    mem_bus_pkg::word_t cpu_wdata_i;
    mem_bus_pkg::strb_t cpu_strb_i;
    logic               cpu_ack_o;
    mem_bus_pkg::word_t cpu_rdata_o;
    logic               cpu_hit_o;
    logic               busy_o;

    mem_bus_pkg::word_t   sh_mem [2**`RAM_AW];      // shadow of main ram
    cache_line_pkg::tag_t sh_tag [2**`CACHE_IDX_W]; // shadow tag bank
    cache_line_pkg::vld_t sh_vld [2**`CACHE_IDX_W];
    int                   errors = 0;
    int                   tests = 0;
    logic [31:0]          rng = 32'd79434;

    cache_top dut0 (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;                     // 100 ns period
    end

    initial
    begin
        #((n_tab + n_rand + 4) * slot_ns);
        $display("watchdog: run did not end within %0d ns", (n_tab + n_rand + 4) * slot_ns);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // expected response from the cache rules, then shadow update
    task automatic model_access(input logic we, input mem_bus_pkg::addr_t addr,
                                input mem_bus_pkg::word_t wdata, input mem_bus_pkg::strb_t strb,
                                output mem_bus_pkg::word_t exp_data, output logic exp_hit);
        cache_line_pkg::idx_t   idx;
        cache_line_pkg::tag_t   tag;
        mem_bus_pkg::ram_widx_t widx;
        cache_line_pkg::vld_t   lane_hit;
        logic                   tag_eq;
        begin
            idx      = addr[`CACHE_IDX_W+1:2];
            tag      = addr[31:`CACHE_IDX_W+2];
            widx     = addr[`RAM_AW+1:2];             // ram aliases upper bits
            tag_eq   = (sh_tag[idx] == tag);
            lane_hit = tag_eq ? sh_vld[idx] : 4'h0;   // bytes owned by this tag
            exp_data = sh_mem[widx];                  // write-through keeps ram current
            if (!we)
            begin
                exp_hit     = tag_eq && (sh_vld[idx] == 4'hf);  // load needs every byte
                sh_tag[idx] = tag;                    // fill on miss, no change on hit
                sh_vld[idx] = 4'hf;
            end
            else
            begin
                exp_hit = 1'b1;
                for (int i = 0; i < 4; i++)
                begin
                    if (strb[i] && !lane_hit[i])
                        exp_hit = 1'b0;               // strobed byte not present
                    if (strb[i])
                        sh_mem[widx][i*8 +: 8] = wdata[i*8 +: 8];
                end
                sh_vld[idx] = (tag_eq ? sh_vld[idx] : 4'h0) | strb;
                sh_tag[idx] = tag;
            end
        end
    endtask

    task automatic run_request(input logic we, input mem_bus_pkg::addr_t addr,
                               input mem_bus_pkg::word_t wdata, input mem_bus_pkg::strb_t strb,
                               output logic got_ack, output mem_bus_pkg::word_t rdata,
                               output logic hit);
        int waited;
        begin
            @(posedge clk);
            cpu_req_i   <= 1'b1;
            cpu_we_i    <= we;
            cpu_addr_i  <= addr;
            cpu_wdata_i <= wdata;
            cpu_strb_i  <= strb;
            @(posedge clk);                           // taken at this edge
            cpu_req_i   <= 1'b0;
            waited  = 0;
            got_ack = 1'b0;
            rdata   = '0;
            hit     = 1'b0;
            while (!got_ack && waited < ack_wait)
            begin
                @(negedge clk);
                if (cpu_ack_o === 1'b1)
                begin
                    got_ack = 1'b1;
                    rdata   = cpu_rdata_o;
                    hit     = cpu_hit_o;
                end
                waited++;
            end
        end
    endtask

    task automatic check_response(input int num, input logic we, input mem_bus_pkg::addr_t addr,
                                  input logic got_ack, input mem_bus_pkg::word_t rdata,
                                  input logic hit, input mem_bus_pkg::word_t exp_data,
                                  input logic exp_hit);
        int bad;
        begin
            bad = 0;
            if (!got_ack)
            begin
                $display("test %0d: no acknowledge within %0d cycles", num, ack_wait);
                bad++;
            end
            else
            begin
                if (hit !== exp_hit)
                begin
                    $display("error: cpu_hit_o 0x%h, expected 0x%h", hit, exp_hit);
                    bad++;
                end
                if (!we && rdata !== exp_data)
                begin
                    $display("error: cpu_rdata_o 0x%08h, expected 0x%08h", rdata, exp_data);
                    bad++;
                end
            end
            errors += bad;
            tests++;
            $display("test %0d %s 0x%08h: %s", num, we ? "store" : "load ", addr,
                     (bad == 0) ? "ok" : "mismatch");
        end
    endtask

    // second request pulsed mid-fetch, exactly one ack expected
    task automatic check_busy_ignore(input int num);
        mem_bus_pkg::word_t exp_data;
        logic               exp_hit;
        int                 acks;
        int                 bad;
        begin
            acks = 0;
            bad  = 0;
            model_access(1'b0, 32'h0000_0c44, 32'h0, 4'h0, exp_data, exp_hit);
            @(posedge clk);
            cpu_req_i  <= 1'b1;
            cpu_we_i   <= 1'b0;
            cpu_addr_i <= 32'h0000_0c44;             // fresh line, miss
            @(posedge clk);
            cpu_req_i  <= 1'b0;
            @(posedge clk);
            cpu_req_i  <= 1'b1;                      // lands in fetch
            @(negedge clk);
            if (busy_o !== 1'b1)
            begin
                $display("error: busy_o 0x%h, expected 0x1", busy_o);
                bad++;
            end
            @(posedge clk);
            cpu_req_i  <= 1'b0;
            repeat (`RAM_LAT + 6)
            begin
                @(negedge clk);
                if (cpu_ack_o === 1'b1)
                begin
                    acks++;
                    if (cpu_rdata_o !== exp_data)
                    begin
                        $display("error: cpu_rdata_o 0x%08h, expected 0x%08h",
                                 cpu_rdata_o, exp_data);
                        bad++;
                    end
                    if (cpu_hit_o !== exp_hit)
                    begin
                        $display("error: cpu_hit_o 0x%h, expected 0x%h", cpu_hit_o, exp_hit);
                        bad++;
                    end
                end
            end
            if (acks != 1)
            begin
                $display("test %0d: %0d acknowledges seen for one accepted request", num, acks);
                bad++;
            end
            errors += bad;
            tests++;
            $display("test %0d busy request ignored: %s", num, (bad == 0) ? "ok" : "mismatch");
        end
    endtask

    initial
    begin
        mem_bus_pkg::word_t exp_data;
        mem_bus_pkg::word_t rdata;
        mem_bus_pkg::word_t wd;
        mem_bus_pkg::addr_t ad;
        mem_bus_pkg::strb_t st;
        logic               exp_hit;
        logic               hit;
        logic               got_ack;
        logic               wr;
        rst_i       = 1'b1;
        cpu_req_i   = 1'b0;
        cpu_we_i    = 1'b0;
        cpu_addr_i  = '0;
        cpu_wdata_i = '0;
        cpu_strb_i  = '0;
        for (int i = 0; i < 2**`RAM_AW; i++)
            sh_mem[i] = '0;                          // ram starts cleared
        for (int i = 0; i < 2**`CACHE_IDX_W; i++)
        begin
            sh_tag[i] = '0;
            sh_vld[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        tests++;
        if (busy_o !== 1'b0 || cpu_ack_o !== 1'b0)
        begin
            $display("error: busy_o 0x%h cpu_ack_o 0x%h, expected 0x0 0x0", busy_o, cpu_ack_o);
            errors++;
        end
        $display("test 0 reset state: %s", (errors == 0) ? "ok" : "mismatch");

        for (int i = 0; i < n_tab; i++)
        begin
            model_access(tab[i].we, tab[i].addr, tab[i].wdata, tab[i].strb, exp_data, exp_hit);
            run_request(tab[i].we, tab[i].addr, tab[i].wdata, tab[i].strb, got_ack, rdata, hit);
            check_response(i + 1, tab[i].we, tab[i].addr, got_ack, rdata, hit,
                           tab[i].rdata, tab[i].hit);
        end

        check_busy_ignore(n_tab + 1);

        // 4 tags on 4 lines, so hits and evictions both occur
        for (int i = 0; i < n_rand; i++)
        begin
            rng = lcg_next(rng);
            wr  = rng[23];
            ad  = {20'h0, rng[31:30], 6'h0, rng[29:28], 2'b00};
            st  = rng[19:16];
            if (st == 4'h0)
                st = 4'hf;
            rng = lcg_next(rng);
            wd  = rng;
            model_access(wr, ad, wd, st, exp_data, exp_hit);
            run_request(wr, ad, wd, st, got_ack, rdata, hit);
            check_response(n_tab + 2 + i, wr, ad, got_ack, rdata, hit, exp_data, exp_hit);
        end

        repeat (2) @(posedge clk);
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- hdl/cache_config.svh
// geometry of the direct-mapped cache
// read latency and size of the backing RAM
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// index bits, one line per index
`define CACHE_IDX_W 6

// tag bits above index and byte offset
`define CACHE_TAG_W (32 - 2 - `CACHE_IDX_W)

// cycles from ram read strobe to done pulse
`define RAM_LAT     4

// main ram word address bits, upper address bits alias
`define RAM_AW      10

`endif

//--- hdl/cache_ctrl.sv
// load/store sequencer of the write-through cache
// hit/miss decision, line fill from main ram, write-through with valid merge
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_ctrl
(
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   cpu_req_i,   // one-cycle request strobe
    input  logic                   cpu_we_i,    // store when high
    input  mem_bus_pkg::addr_t     cpu_addr_i,
    input  mem_bus_pkg::word_t     cpu_wdata_i,
    input  mem_bus_pkg::strb_t     cpu_strb_i,
    output logic                   cpu_ack_o,   // ends every request
    output mem_bus_pkg::word_t     cpu_rdata_o,
    output logic                   cpu_hit_o,
    output logic                   busy_o,
    output mem_bus_pkg::addr_t     c_raddr_o,
    output mem_bus_pkg::addr_t     c_waddr_o,
    output mem_bus_pkg::word_t     c_wd_o,
    output mem_bus_pkg::strb_t     c_we_cb_o,
    output logic                   c_we_ctv_o,
    output cache_line_pkg::vld_t   c_vld_o,
    output cache_line_pkg::tag_t   c_wtag_o,
    input  mem_bus_pkg::word_t     c_rd_i,
    input  cache_line_pkg::vld_t   c_hit_i,
    input  cache_line_pkg::vld_t   c_vld_i,
    output logic                   ram_rd_o,    // read strobe
    output logic                   ram_we_o,    // write strobe
    output mem_bus_pkg::addr_t     ram_addr_o,
    output mem_bus_pkg::word_t     ram_wdata_o,
    output mem_bus_pkg::strb_t     ram_strb_o,
    input  logic                   ram_done_i,  // read data valid
    input  mem_bus_pkg::word_t     ram_rdata_i
);

    typedef enum logic [1:0] {IDLE, LOOKUP, FETCH, REPLY} state_t;

    state_t               state_q;
    state_t               state_d;
    logic                 accept;               // request taken this cycle
    logic                 fill;                 // ram data arrives
    logic                 load_miss;
    logic                 req_hit;              // hit flag of the incoming request
    logic                 we_q;                 // latched request kind
    logic                 miss_q;
    logic                 ack_q;
    logic                 hit_q;
    mem_bus_pkg::addr_t   addr_q;
    mem_bus_pkg::word_t   wdata_q;
    mem_bus_pkg::strb_t   strb_q;
    mem_bus_pkg::word_t   rdata_q;
    cache_line_pkg::vld_t mvld_q;               // merged mask for the store

    assign accept    = (state_q == IDLE) && cpu_req_i;
    assign fill      = (state_q == FETCH) && ram_done_i;
    assign load_miss = !cpu_we_i && !(&c_hit_i);    // load needs all four lanes
    // store reports whether every strobed byte was present
    assign req_hit   = cpu_we_i ? &(c_hit_i | ~cpu_strb_i) : &c_hit_i;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (cpu_req_i) state_d = LOOKUP;
            LOOKUP:  state_d = miss_q ? FETCH : IDLE;
            FETCH:   if (ram_done_i) state_d = REPLY;
            REPLY:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            state_q <= IDLE;
            ack_q   <= 1'b0;
            we_q    <= 1'b0;
            miss_q  <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            ack_q   <= accept ? !load_miss : fill;  // hit/store ack in LOOKUP
            if (accept)
            begin
                we_q   <= cpu_we_i;
                miss_q <= load_miss;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            addr_q  <= cpu_addr_i;
            wdata_q <= cpu_wdata_i;
            strb_q  <= cpu_strb_i;
            rdata_q <= c_rd_i;                  // hit data
            hit_q   <= req_hit;
            // keep old bytes only if the line still belongs to this tag
            mvld_q  <= ((|c_hit_i) ? c_vld_i : 4'b0000) | cpu_strb_i;
        end
        else if (fill)
        begin
            rdata_q <= ram_rdata_i;             // miss data
            hit_q   <= 1'b0;
        end
    end

    // lookup runs on the live address while idle
    assign c_raddr_o  = (state_q == IDLE) ? cpu_addr_i : addr_q;
    assign c_waddr_o  = addr_q;
    assign c_wtag_o   = addr_q[31:`CACHE_IDX_W+2];
    assign c_wd_o     = fill ? ram_rdata_i : wdata_q;
    assign c_we_cb_o  = fill ? 4'b1111 : ((state_q == LOOKUP && we_q) ? strb_q : 4'b0000);
    assign c_we_ctv_o = fill || (state_q == LOOKUP && we_q);
    assign c_vld_o    = fill ? 4'b1111 : mvld_q;   // full line on fill

    assign ram_rd_o    = (state_q == LOOKUP) && miss_q;
    assign ram_we_o    = (state_q == LOOKUP) && we_q;  // write-through
    assign ram_addr_o  = addr_q;
    assign ram_wdata_o = wdata_q;
    assign ram_strb_o  = strb_q;

    assign cpu_ack_o   = ack_q;
    assign cpu_rdata_o = rdata_q;
    assign cpu_hit_o   = hit_q;
    assign busy_o      = (state_q != IDLE);

endmodule

//--- hdl/cache_line_pkg.sv
// types of one cache line
// index, tag, per-byte valid mask and the stored tag/valid record
`include "cache_config.svh"

package cache_line_pkg;

    // line select, address bits above the byte offset
    typedef logic [`CACHE_IDX_W-1:0] idx_t;

    // address bits above the index
    typedef logic [`CACHE_TAG_W-1:0] tag_t;

    // one valid bit per byte lane
    typedef logic [3:0] vld_t;

    // what the tag bank keeps per line
    typedef struct packed {
        vld_t vld;                  // per-byte valid
        tag_t tag;                  // owner of the line
    } tag_valid_t;

endpackage

//--- hdl/cache_store.sv
// cache arrays, four byte lane banks and the tag/valid bank
// tag compare, per-byte hit and same-cycle write forwarding
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_store
(
    input  logic                   clk,
    input  mem_bus_pkg::addr_t     raddr_i,     // lookup address
    input  mem_bus_pkg::addr_t     waddr_i,     // write address
    input  mem_bus_pkg::strb_t     we_cb_i,     // lane write enables
    input  logic                   we_ctv_i,    // tag/valid write enable
    input  mem_bus_pkg::word_t     wd_i,        // lane write data
    input  cache_line_pkg::vld_t   vld_i,       // new valid mask
    input  cache_line_pkg::tag_t   wtag_i,      // new tag
    output mem_bus_pkg::word_t     rd_o,        // lane data, forwarded
    output cache_line_pkg::vld_t   hit_o,       // per-byte hit
    output cache_line_pkg::vld_t   vld_o        // stored mask for merging
);

    cache_line_pkg::idx_t       ridx;           // read line
    cache_line_pkg::idx_t       widx;           // write line
    cache_line_pkg::tag_t       rtag;           // tag of the lookup address
    cache_line_pkg::tag_valid_t tv_rd;          // stored record
    cache_line_pkg::tag_valid_t tv_wd;          // record to store
    mem_bus_pkg::byte_t         lane_rd [4];    // raw bank outputs
    logic                       tag_eq;
    logic                       same_addr;      // write hits the read word

    assign ridx      = raddr_i[`CACHE_IDX_W+1:2];
    assign widx      = waddr_i[`CACHE_IDX_W+1:2];
    assign rtag      = raddr_i[31:`CACHE_IDX_W+2];
    assign same_addr = (waddr_i == raddr_i);
    assign tv_wd     = '{vld: vld_i, tag: wtag_i};

    assign tag_eq = (tv_rd.tag == rtag);
    assign hit_o  = tv_rd.vld & {4{tag_eq}};    // valid and owned
    assign vld_o  = tv_rd.vld;

    for (genvar i = 0; i < 4; i++)
    begin : g_lane
        param_mem
        #(
            .addr_w  ( `CACHE_IDX_W        ),
            .data_t  ( mem_bus_pkg::byte_t )
        )
        bank
        (
            .clk     ( clk                 ),
            .waddr_i ( widx                ),
            .raddr_i ( ridx                ),
            .we_i    ( we_cb_i[i]          ),
            .wd_i    ( wd_i[i*8 +: 8]      ),
            .rd_o    ( lane_rd[i]          )
        );

        // lane written this cycle at the read address returns the new byte
        assign rd_o[i*8 +: 8] = (same_addr && we_cb_i[i]) ? wd_i[i*8 +: 8] : lane_rd[i];
    end

    param_mem
    #(
        .addr_w  ( `CACHE_IDX_W                ),
        .data_t  ( cache_line_pkg::tag_valid_t )
    )
    tag_bank
    (
        .clk     ( clk      ),
        .waddr_i ( widx     ),
        .raddr_i ( ridx     ),
        .we_i    ( we_ctv_i ),
        .wd_i    ( tv_wd    ),
        .rd_o    ( tv_rd    )
    );

endmodule

//--- hdl/cache_top.sv
// cache top level
// controller, cache arrays and main ram
`timescale 1ns/1ps

module cache_top
(
    input  logic               clk,
    input  logic               rst_i,
    input  logic               cpu_req_i,
    input  logic               cpu_we_i,
    input  mem_bus_pkg::addr_t cpu_addr_i,
    input  mem_bus_pkg::word_t cpu_wdata_i,
    input  mem_bus_pkg::strb_t cpu_strb_i,
    output logic               cpu_ack_o,
    output mem_bus_pkg::word_t cpu_rdata_o,
    output logic               cpu_hit_o,
    output logic               busy_o
);

    mem_bus_pkg::addr_t   c_raddr;              // controller to store
    mem_bus_pkg::addr_t   c_waddr;
    mem_bus_pkg::word_t   c_wd;
    mem_bus_pkg::strb_t   c_we_cb;
    logic                 c_we_ctv;
    cache_line_pkg::vld_t c_vld;
    cache_line_pkg::tag_t c_wtag;
    mem_bus_pkg::word_t   c_rd;                 // store back to controller
    cache_line_pkg::vld_t c_hit;
    cache_line_pkg::vld_t c_vld_rd;
    logic                 ram_rd;               // controller to ram
    logic                 ram_we;
    mem_bus_pkg::addr_t   ram_addr;
    mem_bus_pkg::word_t   ram_wdata;
    mem_bus_pkg::strb_t   ram_strb;
    logic                 ram_done;             // ram back to controller
    mem_bus_pkg::word_t   ram_rdata;

    cache_ctrl ctrl0
    (
        .clk         ( clk         ), .rst_i       ( rst_i       ),
        .cpu_req_i   ( cpu_req_i   ), .cpu_we_i    ( cpu_we_i    ),
        .cpu_addr_i  ( cpu_addr_i  ), .cpu_wdata_i ( cpu_wdata_i ),
        .cpu_strb_i  ( cpu_strb_i  ), .cpu_ack_o   ( cpu_ack_o   ),
        .cpu_rdata_o ( cpu_rdata_o ), .cpu_hit_o   ( cpu_hit_o   ),
        .busy_o      ( busy_o      ),
        .c_raddr_o   ( c_raddr     ), .c_waddr_o   ( c_waddr     ),
        .c_wd_o      ( c_wd        ), .c_we_cb_o   ( c_we_cb     ),
        .c_we_ctv_o  ( c_we_ctv    ), .c_vld_o     ( c_vld       ),
        .c_wtag_o    ( c_wtag      ), .c_rd_i      ( c_rd        ),
        .c_hit_i     ( c_hit       ), .c_vld_i     ( c_vld_rd    ),
        .ram_rd_o    ( ram_rd      ), .ram_we_o    ( ram_we      ),
        .ram_addr_o  ( ram_addr    ), .ram_wdata_o ( ram_wdata   ),
        .ram_strb_o  ( ram_strb    ), .ram_done_i  ( ram_done    ),
        .ram_rdata_i ( ram_rdata   )
    );

    cache_store store0
    (
        .clk      ( clk      ), .raddr_i  ( c_raddr  ), .waddr_i ( c_waddr ),
        .we_cb_i  ( c_we_cb  ), .we_ctv_i ( c_we_ctv ), .wd_i    ( c_wd    ),
        .vld_i    ( c_vld    ), .wtag_i   ( c_wtag   ), .rd_o    ( c_rd    ),
        .hit_o    ( c_hit    ), .vld_o    ( c_vld_rd )
    );

    main_ram ram0
    (
        .clk     ( clk       ), .rst_i   ( rst_i     ), .rd_i    ( ram_rd   ),
        .we_i    ( ram_we    ), .addr_i  ( ram_addr  ), .wdata_i ( ram_wdata ),
        .strb_i  ( ram_strb  ), .done_o  ( ram_done  ), .rdata_o ( ram_rdata )
    );

endmodule

//--- hdl/main_ram.sv
// backing word ram, byte-strobed writes and fixed-latency reads
`timescale 1ns/1ps
`include "cache_config.svh"

module main_ram
(
    input  logic               clk,
    input  logic               rst_i,
    input  logic               rd_i,            // read strobe
    input  logic               we_i,            // write strobe
    input  mem_bus_pkg::addr_t addr_i,          // byte address
    input  mem_bus_pkg::word_t wdata_i,
    input  mem_bus_pkg::strb_t strb_i,
    output logic               done_o,          // read data valid
    output mem_bus_pkg::word_t rdata_o
);

    localparam int cnt_w = $clog2(`RAM_LAT + 1);

    mem_bus_pkg::word_t        mem [2**`RAM_AW];
    mem_bus_pkg::ram_widx_t    widx;            // word index, aliased
    mem_bus_pkg::word_t        rdata_q;
    logic [cnt_w-1:0]          cnt_q;           // cycles left until done

    initial
    begin
        for (int i = 0; i < 2**`RAM_AW; i++)
            mem[i] = '0;
    end

    assign widx = addr_i[`RAM_AW+1:2];

    always_ff @(posedge clk)
    begin
        if (we_i)
            for (int i = 0; i < 4; i++)
                if (strb_i[i])
                    mem[widx][i*8 +: 8] <= wdata_i[i*8 +: 8];  // lane write
        if (rd_i)
            rdata_q <= mem[widx];               // held until done
    end

    always_ff @(posedge clk)
    begin
        if (rst_i)
            cnt_q <= '0;
        else if (rd_i)
            cnt_q <= cnt_w'(`RAM_LAT);
        else if (cnt_q != '0)
            cnt_q <= cnt_q - 1'b1;
    end

    assign done_o  = (cnt_q == cnt_w'(1));      // last cycle of the wait
    assign rdata_o = rdata_q;

endmodule

//--- hdl/mem_bus_pkg.sv
// types of the cpu load/store port and the main ram port
`include "cache_config.svh"

package mem_bus_pkg;

    // byte address as seen by the cpu
    typedef logic [31:0] addr_t;

    // one data word, four lanes
    typedef logic [31:0] word_t;

    // lane enables, bit i covers bits 8*i+7 .. 8*i
    typedef logic [3:0]  strb_t;

    // payload of one lane bank
    typedef logic [7:0]  byte_t;

    // word index inside main ram
    typedef logic [`RAM_AW-1:0] ram_widx_t;

endpackage

//--- hdl/param_mem.sv
// simple dual-port memory, clocked write and combinational read
`timescale 1ns/1ps

module param_mem
#(
    parameter int  addr_w = 6,                  // index bits
    parameter type data_t = logic [7:0]         // stored payload
)(
    input  logic              clk,
    input  logic [addr_w-1:0] waddr_i,          // write index
    input  logic [addr_w-1:0] raddr_i,          // read index
    input  logic              we_i,
    input  data_t             wd_i,
    output data_t             rd_o
);

    data_t mem [2**addr_w];                     // storage array

    // all entries start cleared, so valid masks read zero
    initial
    begin
        for (int i = 0; i < 2**addr_w; i++)
            mem[i] = '0;
    end

    always_ff @(posedge clk)
    begin
        if (we_i)
            mem[waddr_i] <= wd_i;               // single write port
    end

    assign rd_o = mem[raddr_i];                 // async read

endmodule

//--- run.sh
#!/bin/sh
# compile the cache testbench with verilator, run it, search the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f all.f --top-module cache_tb -Mdir obj_dir
./obj_dir/Vcache_tb | tee sim.log
if grep -q "Simulation PASSED" sim.log; then
    echo "run.sh: pass"
else
    echo "run.sh: fail"
    exit 1
fi
